//--- bench/irq_patterns.txt
# gpio uart0 uart1 i2c0 i2c1 spi0 spi1 pattgen aon usbdev revoker enable claim complete cid
# then hold (decimal edges), expected irq_o and expected irq_id_o; all other fields in hex
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 0 0 00 3 0 00
00000000 000 000 0000 0000 0 0 0 0 00000 1 ffffffff 0 0 00 3 1 01
00000000 000 000 0000 0000 0 0 0 0 20000 0 ffffffff 1 0 00 3 1 03
00000000 000 000 0000 0000 0 0 2 0 00000 0 ffffffff 1 1 01 3 1 06
00000000 000 000 0000 0000 0 0 0 1 00000 0 ffffffff 1 1 03 3 1 07
00000000 100 000 0000 0000 0 0 0 0 00000 0 ffffffff 1 1 06 3 1 08
00000000 000 010 0000 0000 0 0 0 0 00000 0 ffffffff 1 1 07 3 1 09
00000000 000 000 4000 0000 0 0 0 0 00000 0 ffffffff 1 1 08 3 1 10
00000000 000 000 0000 0001 0 0 0 0 00000 0 ffffffff 1 1 09 3 1 11
00000000 000 000 0000 0000 2 0 0 0 00000 0 ffffffff 1 1 10 3 1 18
00000000 000 000 0000 0000 0 1 0 0 00000 0 ffffffff 1 1 11 3 1 19
80000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 1 1 18 3 1 1c
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 1 1 19 2 0 00
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 0 1 1c 3 0 00
00000001 000 010 4000 0000 0 0 0 0 00001 0 ffffffff 0 0 00 3 1 03
00000001 000 010 4000 0000 0 0 0 0 00001 0 ffffffff 1 0 00 2 1 09
00000001 000 010 4000 0000 0 0 0 0 00001 0 ffffffff 1 0 00 2 1 10
00000001 000 010 4000 0000 0 0 0 0 00001 0 ffffffff 1 0 00 2 1 1c
00000001 000 010 4000 0000 0 0 0 0 00001 0 ffffffff 1 0 00 2 0 00
00000001 000 010 4000 0000 0 0 0 0 00001 0 ffffffff 1 0 00 2 0 00
00000001 000 010 4000 0000 0 0 0 0 00001 0 ffffffff 0 1 09 3 1 09
00000001 000 010 4000 0000 0 0 0 0 00001 0 ffffffff 1 0 00 2 0 00
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 0 1 03 1 0 00
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 0 1 09 1 0 00
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 0 1 10 1 0 00
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 0 1 1c 3 0 00
00000000 000 000 0000 0001 0 0 0 0 00000 0 fffdffff 0 0 00 4 0 00
00000000 000 000 0000 0001 0 0 0 0 00000 0 ffffffff 0 0 00 1 1 11
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 1 0 00 2 0 00
00000000 000 000 0000 0000 0 0 0 0 00000 0 ffffffff 0 1 11 3 0 00

//--- verilog.f
+incdir+bench
hdl/irq_pkg.sv
hdl/intr_collect.sv
hdl/intr_gateway.sv
hdl/intr_arbiter.sv
hdl/irq_fabric_top.sv
bench/irq_fabric_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds irq_fabric_tb with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module irq_fabric_tb -f verilog.f || exit 1
out="$(./obj_dir/Virq_fabric_tb)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All checks passed" && exit 0 || exit 1

//--- bench/irq_checks.svh
/* Compare tasks and error counters for the interrupt fabric testbench.
   Included inside the testbench module body after the irq_pkg import. */
`ifndef IRQ_CHECKS_SVH
`define IRQ_CHECKS_SVH

  int irq_errors  = 0;
  int id_errors   = 0;
  int misc_errors = 0;

  task automatic check_irq(input logic act, input logic exp, input int step_no);
    if (act !== exp) begin
      $display("Error: irq_o = 0x%h, expected 0x%h at step %0d", act, exp, step_no);
      irq_errors++;
    end
  endtask

  task automatic check_id(input src_id_t act, input src_id_t exp, input int step_no);
    if (act !== exp) begin
      $display("Error: irq_id_o = 0x%h, expected 0x%h at step %0d", act, exp, step_no);
      id_errors++;
    end
  endtask

`endif

//--- bench/irq_fabric_tb.sv
/* Testbench for irq_fabric_top. Reads bench/irq_patterns.txt, so it runs
   from the project root. Each step is checked 1 ns after its last held edge. */
`timescale 1ns/10ps

module irq_fabric_tb;
  import irq_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int MAX_HOLD     = 64;

  // Named after the DUT ports so the instance connects by name
  logic                      clk_sys_i;
  logic                      reset_i;
  logic [GPIO_INTR_W-1:0]    gpio_intr_i;
  logic [UART_INTR_W-1:0]    uart0_intr_i;
  logic [UART_INTR_W-1:0]    uart1_intr_i;
  logic [I2C_INTR_W-1:0]     i2c0_intr_i;
  logic [I2C_INTR_W-1:0]     i2c1_intr_i;
  logic [SPI_INTR_W-1:0]     spi_host0_intr_i;
  logic [SPI_INTR_W-1:0]     spi_host1_intr_i;
  logic [PATTGEN_INTR_W-1:0] pattgen_intr_i;
  logic [AON_INTR_W-1:0]     aon_timer_intr_i;
  logic [USBDEV_INTR_W-1:0]  usbdev_intr_i;
  logic                      revoker_intr_i;
  logic [NUM_SRC-1:0]        enable_i;
  logic                      claim_i;
  logic                      complete_i;
  src_id_t                   complete_id_i;
  logic                      irq_o;
  src_id_t                   irq_id_o;
  int                        step = 0;

  `include "irq_checks.svh"

  irq_fabric_top UUT (.*);

  initial begin
    clk_sys_i = 1'b0;
    forever begin
      #5 clk_sys_i = ~clk_sys_i;
    end
  end

  // Strobes last one cycle, the rest of the step is held
  task automatic hold_step(input int cycles);
    int n;
    n = cycles;
    if (n < 1 || n > MAX_HOLD) begin
      $display("Hold of %0d cycles at step %0d is out of range", cycles, step);
      misc_errors++;
      n = 1;
    end
    for (int i = 0; i < n; i++) begin
      @(posedge clk_sys_i);
      #1;
      claim_i    = 1'b0;
      complete_i = 1'b0;
    end
  endtask

  // Drives one pattern line, holds it, then compares irq_o and irq_id_o
  task automatic apply_step(input string line);
    int      n_read;
    int      hold;
    logic    exp_irq;
    src_id_t exp_id;
    n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h",
                     gpio_intr_i, uart0_intr_i, uart1_intr_i, i2c0_intr_i, i2c1_intr_i,
                     spi_host0_intr_i, spi_host1_intr_i, pattgen_intr_i, aon_timer_intr_i,
                     usbdev_intr_i, revoker_intr_i, enable_i, claim_i, complete_i,
                     complete_id_i, hold, exp_irq, exp_id);
    if (n_read != 18) begin
      $display("Pattern line with %0d of 18 fields was skipped: %s", n_read, line);
      misc_errors++;
      claim_i    = 1'b0;
      complete_i = 1'b0;
    end else begin
      step++;
      hold_step(hold);
      check_irq(irq_o, exp_irq, step);
      check_id(irq_id_o, exp_id, step);
    end
  endtask

  initial begin
    string line;
    int    fd;
    {gpio_intr_i, uart0_intr_i, uart1_intr_i, i2c0_intr_i, i2c1_intr_i,
     spi_host0_intr_i, spi_host1_intr_i, pattgen_intr_i, aon_timer_intr_i, usbdev_intr_i,
     revoker_intr_i, enable_i, claim_i, complete_i, complete_id_i} = '0;
    reset_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_sys_i);
    #1;
    reset_i = 1'b0;

    // Idle outputs straight out of reset
    check_irq(irq_o, 1'b0, 0);
    check_id(irq_id_o, '0, 0);

    fd = $fopen("bench/irq_patterns.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        // Comment and blank lines carry no step
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          apply_step(line);
        end
      end
      $fclose(fd);
    end
    if (step == 0) begin
      $display("No pattern steps were run from bench/irq_patterns.txt");
      misc_errors++;
    end

    $display("Errors: irq_o %0d, irq_id_o %0d, other %0d",
             irq_errors, id_errors, misc_errors);
    if (irq_errors + id_errors + misc_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- hdl/irq_fabric_top.sv
/* Interrupt fabric top, all on clk_sys_i. Fixed latency of 3 edges from a
   source level to irq_o. No programmable priority or threshold. */
`timescale 1ns/10ps

module irq_fabric_top (
  input  logic                               clk_sys_i,
  input  logic                               reset_i,

  // Peripheral interrupt bundles
  input  logic [irq_pkg::GPIO_INTR_W-1:0]    gpio_intr_i,
  input  logic [irq_pkg::UART_INTR_W-1:0]    uart0_intr_i,
  input  logic [irq_pkg::UART_INTR_W-1:0]    uart1_intr_i,
  input  logic [irq_pkg::I2C_INTR_W-1:0]     i2c0_intr_i,
  input  logic [irq_pkg::I2C_INTR_W-1:0]     i2c1_intr_i,
  input  logic [irq_pkg::SPI_INTR_W-1:0]     spi_host0_intr_i,
  input  logic [irq_pkg::SPI_INTR_W-1:0]     spi_host1_intr_i,
  input  logic [irq_pkg::PATTGEN_INTR_W-1:0] pattgen_intr_i,
  input  logic [irq_pkg::AON_INTR_W-1:0]     aon_timer_intr_i,
  input  logic [irq_pkg::USBDEV_INTR_W-1:0]  usbdev_intr_i,
  input  logic                               revoker_intr_i,

  // Target side
  input  logic [irq_pkg::NUM_SRC-1:0]        enable_i,
  input  logic                               claim_i,
  input  logic                               complete_i,
  input  irq_pkg::src_id_t                   complete_id_i,
  output logic                               irq_o,
  output irq_pkg::src_id_t                   irq_id_o
);
  import irq_pkg::*;

  src_vec_u src_vec;
  src_vec_u pending;
  logic     claim;
  src_id_t  claim_id;

  intr_collect u_intr_collect (
    .clk_sys_i,
    .reset_i,
    .gpio_intr_i,
    .uart0_intr_i,
    .uart1_intr_i,
    .i2c0_intr_i,
    .i2c1_intr_i,
    .spi_host0_intr_i,
    .spi_host1_intr_i,
    .pattgen_intr_i,
    .aon_timer_intr_i,
    .usbdev_intr_i,
    .revoker_intr_i,
    .src_vec_o        (src_vec)
  );

  intr_gateway u_intr_gateway (
    .clk_sys_i,
    .reset_i,
    .src_vec_i     (src_vec),
    .claim_i       (claim),
    .claim_id_i    (claim_id),
    .complete_i,
    .complete_id_i,
    .pending_o     (pending)
  );

  intr_arbiter u_intr_arbiter (
    .clk_sys_i,
    .reset_i,
    .pending_i  (pending),
    .enable_i,
    .claim_i,
    .claim_o    (claim),
    .claim_id_o (claim_id),
    .irq_o,
    .irq_id_o
  );

endmodule

//--- hdl/intr_arbiter.sv
/* Stage 3. Fixed priority, the lowest enabled pending ID wins.
   irq_o and irq_id_o are registered, one edge behind pending and enable. */
`timescale 1ns/10ps

module intr_arbiter (
  input  logic                         clk_sys_i,
  input  logic                         reset_i,

  input  irq_pkg::src_vec_u            pending_i,
  input  logic [irq_pkg::NUM_SRC-1:0]  enable_i,
  input  logic                         claim_i,

  // Claim back to the gateway
  output logic                         claim_o,
  output irq_pkg::src_id_t             claim_id_o,

  // Target notification
  output logic                         irq_o,
  output irq_pkg::src_id_t             irq_id_o
);
  import irq_pkg::*;

  logic [NUM_SRC-1:0] masked;
  logic               win_vld;
  src_id_t            win_id;

  assign masked = pending_i.flat & enable_i;

  // Scan down so the lowest set ID is the last one written
  always_comb begin
    win_vld = 1'b0;
    win_id  = '0;
    for (int i = NUM_SRC - 1; i >= 1; i--) begin
      if (masked[i]) begin
        win_vld = 1'b1;
        win_id  = src_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      irq_o    <= 1'b0;
      irq_id_o <= '0;
    end else begin
      irq_o    <= win_vld;
      irq_id_o <= win_id;
    end
  end

  // Claim with no interrupt presented is dropped here
  assign claim_o    = claim_i & irq_o;
  assign claim_id_o = irq_id_o;

  a_id_with_irq: assert property (@(posedge clk_sys_i) disable iff (reset_i)
    (irq_id_o != '0) == irq_o);

endmodule

//--- hdl/intr_gateway.sv
/* Stage 2. Claims must be spaced at least two cycles apart, since the
   presented ID only moves one edge after the claim. Complete must name
   a source that is in service. */
`timescale 1ns/10ps

module intr_gateway (
  input  logic              clk_sys_i,
  input  logic              reset_i,

  input  irq_pkg::src_vec_u src_vec_i,

  // Claim from the arbiter, complete from the core side
  input  logic              claim_i,
  input  irq_pkg::src_id_t  claim_id_i,
  input  logic              complete_i,
  input  irq_pkg::src_id_t  complete_id_i,

  output irq_pkg::src_vec_u pending_o
);
  import irq_pkg::*;

  src_vec_u           pending_q;
  src_vec_u           pending_d;
  logic [NUM_SRC-1:0] in_service_q;
  logic [NUM_SRC-1:0] in_service_d;
  logic [NUM_SRC-1:0] claim_mask;
  logic [NUM_SRC-1:0] complete_mask;

  assign claim_mask    = claim_i    ? (NUM_SRC'(1) << claim_id_i)    : '0;
  assign complete_mask = complete_i ? (NUM_SRC'(1) << complete_id_i) : '0;

  // Level sources are gated while in service
  // A claim in the same cycle wins over a new set
  always_comb begin
    pending_d.flat = (pending_q.flat | (src_vec_i.flat & ~in_service_q)) & ~claim_mask;
    in_service_d   = (in_service_q | claim_mask) & ~complete_mask;
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      pending_q    <= pending_d;
      in_service_q <= in_service_d;
    end
  end

  assign pending_o = pending_q;

  // Arbiter only forwards claims for a source it saw pending
  a_claim_valid: assert property (@(posedge clk_sys_i) disable iff (reset_i)
    claim_i |-> (claim_id_i != '0) && pending_q.flat[claim_id_i]);

  a_complete_valid: assert property (@(posedge clk_sys_i) disable iff (reset_i)
    complete_i |-> in_service_q[complete_id_i]);

endmodule

//--- hdl/intr_collect.sv
/* Stage 1. Bundle inputs are levels already in the clk_sys_i domain.
   One register stage, so a source shows in src_vec_o one edge later. */
`timescale 1ns/10ps

module intr_collect (
  input  logic                               clk_sys_i,
  input  logic                               reset_i,

  // Peripheral interrupt bundles
  input  logic [irq_pkg::GPIO_INTR_W-1:0]    gpio_intr_i,
  input  logic [irq_pkg::UART_INTR_W-1:0]    uart0_intr_i,
  input  logic [irq_pkg::UART_INTR_W-1:0]    uart1_intr_i,
  input  logic [irq_pkg::I2C_INTR_W-1:0]     i2c0_intr_i,
  input  logic [irq_pkg::I2C_INTR_W-1:0]     i2c1_intr_i,
  input  logic [irq_pkg::SPI_INTR_W-1:0]     spi_host0_intr_i,
  input  logic [irq_pkg::SPI_INTR_W-1:0]     spi_host1_intr_i,
  input  logic [irq_pkg::PATTGEN_INTR_W-1:0] pattgen_intr_i,
  input  logic [irq_pkg::AON_INTR_W-1:0]     aon_timer_intr_i,
  input  logic [irq_pkg::USBDEV_INTR_W-1:0]  usbdev_intr_i,
  input  logic                               revoker_intr_i,

  output irq_pkg::src_vec_u                  src_vec_o
);
  import irq_pkg::*;

  src_vec_u src_vec_d;

  // Any bit of a bundle raises its slot
  always_comb begin
    src_vec_d                 = '0;
    src_vec_d.slots.revoker   = revoker_intr_i;
    src_vec_d.slots.usbdev    = |usbdev_intr_i;
    src_vec_d.slots.pattgen   = |pattgen_intr_i;
    src_vec_d.slots.aon_timer = |aon_timer_intr_i;
    src_vec_d.slots.uart0     = |uart0_intr_i;
    src_vec_d.slots.uart1     = |uart1_intr_i;
    src_vec_d.slots.i2c0      = |i2c0_intr_i;
    src_vec_d.slots.i2c1      = |i2c1_intr_i;
    src_vec_d.slots.spi_host0 = |spi_host0_intr_i;
    src_vec_d.slots.spi_host1 = |spi_host1_intr_i;
    src_vec_d.slots.gpio      = |gpio_intr_i;
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      src_vec_o <= '0;
    end else begin
      src_vec_o <= src_vec_d;
    end
  end

  // Named slots must land on the IDs the rest of the fabric decodes
  a_rsvd_zero: assert property (@(posedge clk_sys_i) disable iff (reset_i)
    (src_vec_o.flat & ~SRC_MASK) == '0);

endmodule

//--- hdl/irq_pkg.sv
/* Shared widths, slot IDs and the source vector layout of the interrupt fabric.
   Slot map follows the chip top. ID 0 is never a source and means no interrupt. */

package irq_pkg;

  localparam int unsigned NUM_SRC  = 32;
  localparam int unsigned SRC_ID_W = 5;

  // Peripheral interrupt bundle widths
  localparam int unsigned GPIO_INTR_W    = 32;
  localparam int unsigned UART_INTR_W    = 9;
  localparam int unsigned I2C_INTR_W     = 15;
  localparam int unsigned SPI_INTR_W     = 2;
  localparam int unsigned PATTGEN_INTR_W = 2;
  localparam int unsigned AON_INTR_W     = 2;
  localparam int unsigned USBDEV_INTR_W  = 18;

  // Slot IDs
  localparam int unsigned ID_REVOKER   = 1;
  localparam int unsigned ID_USBDEV    = 3;
  localparam int unsigned ID_PATTGEN   = 6;
  localparam int unsigned ID_AON_TIMER = 7;
  localparam int unsigned ID_UART0     = 8;
  localparam int unsigned ID_UART1     = 9;
  localparam int unsigned ID_I2C0      = 16;
  localparam int unsigned ID_I2C1      = 17;
  localparam int unsigned ID_SPI_HOST0 = 24;
  localparam int unsigned ID_SPI_HOST1 = 25;
  localparam int unsigned ID_GPIO      = 28;

  // Slots that have a source behind them, all others read as zero
  localparam logic [NUM_SRC-1:0] SRC_MASK =
      (NUM_SRC'(1) << ID_REVOKER)   | (NUM_SRC'(1) << ID_USBDEV)    |
      (NUM_SRC'(1) << ID_PATTGEN)   | (NUM_SRC'(1) << ID_AON_TIMER) |
      (NUM_SRC'(1) << ID_UART0)     | (NUM_SRC'(1) << ID_UART1)     |
      (NUM_SRC'(1) << ID_I2C0)      | (NUM_SRC'(1) << ID_I2C1)      |
      (NUM_SRC'(1) << ID_SPI_HOST0) | (NUM_SRC'(1) << ID_SPI_HOST1) |
      (NUM_SRC'(1) << ID_GPIO);

  typedef logic [SRC_ID_W-1:0] src_id_t;

  // Named view of the source word, MSB first
  typedef struct packed {
    logic [2:0] rsvd_31_29;
    logic       gpio;
    logic [1:0] rsvd_27_26;
    logic       spi_host1;
    logic       spi_host0;
    logic [5:0] rsvd_23_18;
    logic       i2c1;
    logic       i2c0;
    logic [5:0] rsvd_15_10;
    logic       uart1;
    logic       uart0;
    logic       aon_timer;
    logic       pattgen;
    logic [1:0] rsvd_5_4;
    logic       usbdev;
    logic       rsvd_2;
    logic       revoker;
    logic       rsvd_0;
  } src_slots_t;

  typedef union packed {
    logic [NUM_SRC-1:0] flat;
    src_slots_t         slots;
  } src_vec_u;

endpackage
